// File: riscv_pipe.f
+incdir+include
rtl/riscv_pipe_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/riscv_pipe_top.sv
bench/riscv_pipe_assertions.sv
bench/riscv_pipe_tb.sv

// File: bench/riscv_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_pipe_consts.svh"

module riscv_pipe_tb;

  import riscv_pipe_pkg::*;

  typedef struct packed {
    logic  valid;
    word_t addr;
    word_t data;
  } store_t;

  // f3 of the dependent chain with the first op in the low bits
  localparam logic [29:0] CHAIN_F3 = {3'b011, 3'b010, 3'b101, 3'b101, 3'b001,
                                      3'b111, 3'b110, 3'b100, 3'b000, 3'b000};

  logic        clk;
  logic        rst_i;
  word_t       imem_addr;
  word_t       imem_data;
  word_t       dmem_addr;
  word_t       dmem_wdata;
  word_t       dmem_rdata;
  logic        dmem_we;
  logic        dmem_re;
  word_t       imem [0:1023];
  word_t       dmem [0:255];
  word_t       model_regs [0:31];
  word_t       model_mem [0:255];
  word_t       prog [$];
  store_t      exp_q [$];
  logic [15:0] lfsr_state;
  string       test_name;
  int unsigned mismatches;
  int unsigned timeouts;
  int unsigned other_errors;
  int unsigned cycles_out_of_reset;
  int unsigned quiet_cycles;
  int unsigned pc_repeats;
  int unsigned loads_seen;
  int unsigned loads_expected;
  word_t       prev_pc;

  riscv_pipe_top u_riscv_pipe_top (
    .clk          (clk),
    .rst_i        (rst_i),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_we_o    (dmem_we),
    .dmem_re_o    (dmem_re),
    .dmem_rdata_i (dmem_rdata)
  );

  always #10 clk = ~clk;

  // ==========================================================
  // memories
  // ==========================================================

  assign imem_data = imem[imem_addr[11:2]];

  always @(posedge clk) begin
    if (!rst_i && dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
    dmem_rdata <= dmem[dmem_addr[9:2]];
  end

  function automatic word_t fill_word(input int unsigned idx);
    return (idx * 32'h9e3779b1) ^ 32'hc3a50000;
  endfunction

  // ==========================================================
  // encoders, random bits and reference model
  // ==========================================================

  function automatic word_t enc_r(input logic alt, input logic [2:0] f3, input reg_addr_t rd,
                                  input reg_addr_t rs1, input reg_addr_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RP_OPC_OP};
  endfunction

  function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                  input reg_addr_t rd, input reg_addr_t rs1,
                                  input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RP_OPC_STORE};
  endfunction

  function automatic word_t enc_u(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, `RP_OPC_LUI};
  endfunction

  // galois lfsr stepped once per bit
  function automatic word_t rand_bits(input int n);
    word_t v;
    logic  b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b          = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
        lfsr_state = lfsr_state ^ 16'hb400;
      end
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs one instruction on the model state, returns its store if any
  function automatic store_t ref_exec(input word_t instr);
    store_t    st;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
    word_t     r;
    word_t     imm_i;
    logic      wr;
    rd    = instr[11:7];
    a     = model_regs[instr[19:15]];
    b     = model_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    st    = '0;
    wr    = 1'b1;
    r     = '0;
    case (instr[6:0])
      `RP_OPC_OP:    r = alu_ref(instr[14:12], instr[30], a, b);
      `RP_OPC_OPIMM: r = alu_ref(instr[14:12], instr[14:12] == 3'b101 && instr[30], a, imm_i);
      `RP_OPC_LUI:   r = {instr[31:12], 12'b0};
      `RP_OPC_LOAD: begin
        a = a + imm_i;
        r = model_mem[a[9:2]];
      end
      `RP_OPC_STORE: begin
        wr       = 1'b0;
        st.valid = 1'b1;
        st.addr  = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
        st.data  = b;
        model_mem[st.addr[9:2]] = b;
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != '0) begin
      model_regs[rd] = r;
    end
    return st;
  endfunction

  // ==========================================================
  // compare process
  // ==========================================================

  always @(posedge clk) begin : compare
    store_t expected;
    if (rst_i) begin
      cycles_out_of_reset = 0;
      pc_repeats          = 0;
      loads_seen          = 0;
    end else begin
      if (cycles_out_of_reset < quiet_cycles) begin
        assert (!dmem_we && !dmem_re) else begin
          $display("%s: data port active before any instruction reached memory", test_name);
          other_errors++;
        end
      end
      if (cycles_out_of_reset > 0 && imem_addr == prev_pc) begin
        pc_repeats++;
      end
      if (dmem_re) begin
        loads_seen++;
      end
      prev_pc = imem_addr;
      cycles_out_of_reset++;
      if (dmem_we) begin
        assert (exp_q.size() != 0) else begin
          $display("%s: unexpected store of %h to %h", test_name, dmem_wdata, dmem_addr);
          other_errors++;
        end
        if (exp_q.size() != 0) begin
          expected = exp_q.pop_front();
          assert (dmem_addr == expected.addr) else begin
            $display("FAILED %s store address expected %h actual %h",
                     test_name, expected.addr, dmem_addr);
            mismatches++;
          end
          assert (dmem_wdata == expected.data) else begin
            $display("FAILED %s store data expected %h actual %h",
                     test_name, expected.data, dmem_wdata);
            mismatches++;
          end
        end
      end
    end
  end

  // ==========================================================
  // programs
  // ==========================================================

  task automatic emit(input word_t instr);
    prog.push_back(instr);
  endtask

  task automatic store_all_regs(input int base);
    for (int r = 0; r < 32; r++) begin
      emit(enc_s(5'(r), 5'd0, 12'(base + 4 * r)));
    end
  endtask

  task automatic gen_random(input int count);
    int        kind;
    logic [2:0] f3;
    logic [11:0] imm;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    for (int i = 0; i < count; i++) begin
      kind = rand_bits(3);
      f3   = 3'(rand_bits(3));
      rd   = reg_addr_t'(rand_bits(3));
      rs1  = reg_addr_t'(rand_bits(3));
      rs2  = reg_addr_t'(rand_bits(3));
      case (kind)
        0, 1, 2: emit(enc_r((f3 == 3'b000 || f3 == 3'b101) ? rand_bits(1) : 1'b0,
                            f3, rd, rs1, rs2));
        3: begin
          imm = 12'(rand_bits(12));
          if (f3 == 3'b001) begin
            imm[11:5] = '0;
          end else if (f3 == 3'b101) begin
            imm[11:5] = {1'b0, 1'(rand_bits(1)), 5'b0};
          end
          emit(enc_i(`RP_OPC_OPIMM, f3, rd, rs1, imm));
        end
        4: emit(enc_u(rd, 20'(rand_bits(20))));
        5: emit(enc_i(`RP_OPC_LOAD, 3'b010, rd, 5'd0, {4'b0, 6'(rand_bits(6)), 2'b0}));
        default: emit(enc_s(rs2, 5'd0, {4'b0, 6'(rand_bits(6)), 2'b0}));
      endcase
    end
  endtask

  // reset, load memories, queue the reference stores and wait for them
  task automatic run_program(input string name, input int expect_repeats);
    store_t     st;
    int         cycles;
    int         first_mem;
    logic [6:0] opc;
    test_name = name;
    @(posedge clk);
    rst_i <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < 1024; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : `RP_NOP_INSTR;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i]      = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    exp_q.delete();
    loads_expected = 0;
    first_mem      = -1;
    foreach (prog[i]) begin
      opc = prog[i][6:0];
      if (opc == `RP_OPC_LOAD) begin
        loads_expected++;
      end
      if (first_mem < 0 && (opc == `RP_OPC_LOAD || opc == `RP_OPC_STORE)) begin
        first_mem = i;
      end
      st = ref_exec(prog[i]);
      if (st.valid) begin
        exp_q.push_back(st);
      end
    end
    // the data port stays idle until the first memory op is 3 stages down
    quiet_cycles = 3 + ((first_mem < 0) ? prog.size() : first_mem);
    repeat (7) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    assert (imem_addr == `RP_RESET_PC) else begin
      $display("FAILED %s reset pc expected %h actual %h", name, `RP_RESET_PC, imem_addr);
      mismatches++;
    end
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 4 * prog.size() + 50) begin
      @(posedge clk);
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: timed out with %0d stores never seen", name, exp_q.size());
      timeouts++;
    end
    // stray stores after the last expected one
    repeat (8) @(posedge clk);
    assert (loads_seen == loads_expected) else begin
      $display("FAILED %s data reads expected %0d actual %0d",
               name, loads_expected, loads_seen);
      mismatches++;
    end
    if (expect_repeats >= 0) begin
      assert (pc_repeats == expect_repeats) else begin
        $display("FAILED %s fetch repeats expected %0d actual %0d",
                 name, expect_repeats, pc_repeats);
        mismatches++;
      end
    end
    prog.delete();
  endtask

  initial begin
    clk            = 1'b0;
    rst_i          = 1'b1;
    dmem_rdata     = '0;
    lfsr_state     = 16'd43309;
    mismatches     = 0;
    timeouts       = 0;
    other_errors   = 0;
    quiet_cycles   = 3;
    loads_seen     = 0;
    loads_expected = 0;
    prev_pc        = '0;
    for (int i = 0; i < 1024; i++) begin
      imem[i] = `RP_NOP_INSTR;
    end

    // each op reads the previous result and odd ones also the result before that
    emit(enc_i(`RP_OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h123));
    emit(enc_i(`RP_OPC_OPIMM, 3'b000, 5'd2, 5'd0, 12'hfb3));
    for (int k = 0; k < 10; k++) begin
      emit(enc_r(k == 1 || k == 7, CHAIN_F3[3 * k +: 3], 5'(k + 3), 5'(k + 2),
                 (k % 2 == 1) ? 5'(k + 1) : 5'd1));
    end
    store_all_regs(0);
    run_program("alu_chain", -1);

    emit(enc_i(`RP_OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'hffb));
    emit(enc_i(`RP_OPC_OPIMM, 3'b010, 5'd2, 5'd1, 12'h003));
    emit(enc_i(`RP_OPC_OPIMM, 3'b011, 5'd3, 5'd1, 12'h003));
    emit(enc_i(`RP_OPC_OPIMM, 3'b100, 5'd4, 5'd1, 12'h5a5));
    emit(enc_i(`RP_OPC_OPIMM, 3'b110, 5'd5, 5'd4, 12'h0f0));
    emit(enc_i(`RP_OPC_OPIMM, 3'b111, 5'd6, 5'd5, 12'h7ff));
    emit(enc_i(`RP_OPC_OPIMM, 3'b001, 5'd7, 5'd1, 12'h007));
    emit(enc_i(`RP_OPC_OPIMM, 3'b101, 5'd8, 5'd1, 12'h004));
    emit(enc_i(`RP_OPC_OPIMM, 3'b101, 5'd9, 5'd1, 12'h404));
    emit(enc_u(5'd10, 20'hdead5));
    emit(enc_i(`RP_OPC_OPIMM, 3'b000, 5'd11, 5'd10, 12'h7ef));
    // x0 writes must leave it zero
    emit(enc_i(`RP_OPC_OPIMM, 3'b000, 5'd0, 5'd1, 12'h037));
    emit(enc_u(5'd0, 20'h12345));
    emit(enc_r(1'b0, 3'b000, 5'd0, 5'd1, 5'd10));
    emit(enc_i(`RP_OPC_OPIMM, 3'b000, 5'd12, 5'd0, 12'h001));
    store_all_regs(256);
    run_program("imm_lui_x0", -1);

    emit(enc_i(`RP_OPC_LOAD, 3'b010, 5'd5, 5'd0, 12'd16));
    emit(enc_r(1'b0, 3'b000, 5'd6, 5'd5, 5'd5));
    emit(enc_s(5'd6, 5'd0, 12'd200));
    emit(enc_s(5'd5, 5'd0, 12'd204));
    run_program("load_use", 1);

    gen_random(400);
    store_all_regs(512);
    run_program("random", -1);

    $display("summary: %0d mismatches, %0d timeouts, %0d other errors, %0d assertion failures",
             mismatches, timeouts, other_errors,
             u_riscv_pipe_top.u_riscv_pipe_assertions.fail_count);
    if (mismatches + timeouts + other_errors +
        u_riscv_pipe_top.u_riscv_pipe_assertions.fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/riscv_pipe_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_assertions (
  input logic                  clk,
  input logic                  rst_i,
  input riscv_pipe_pkg::word_t imem_addr_i,
  input riscv_pipe_pkg::word_t dmem_addr_i,
  input riscv_pipe_pkg::word_t dmem_wdata_i,
  input logic                  dmem_we_i,
  input logic                  dmem_re_i,
  input logic                  stall_i
);

  int unsigned fail_count = 0;

  // one memory op per instruction
  a_no_read_write: assert property (@(posedge clk) disable iff (rst_i)
      !(dmem_we_i && dmem_re_i))
    else begin
      fail_count++;
      $error("data port read and write strobes high together");
    end

  // no branches, so the pc only advances or holds
  a_pc_step: assert property (@(posedge clk) disable iff (rst_i)
      !$past(rst_i) |-> (imem_addr_i == $past(imem_addr_i) + 32'd4 ||
                         imem_addr_i == $past(imem_addr_i)))
    else begin
      fail_count++;
      $error("fetch address neither stepped by 4 nor held");
    end

  // the bubble clears the load, so a stall cannot repeat
  a_single_stall: assert property (@(posedge clk) disable iff (rst_i)
      stall_i |=> !stall_i)
    else begin
      fail_count++;
      $error("load-use stall lasted two cycles");
    end

  a_dmem_known: assert property (@(posedge clk) disable iff (rst_i)
      !$isunknown({dmem_we_i, dmem_re_i, dmem_addr_i, dmem_wdata_i}))
    else begin
      fail_count++;
      $error("data port output unknown after reset");
    end

endmodule

bind riscv_pipe_top riscv_pipe_assertions u_riscv_pipe_assertions (
  .clk          (clk),
  .rst_i        (rst_i),
  .imem_addr_i  (imem_addr_o),
  .dmem_addr_i  (dmem_addr_o),
  .dmem_wdata_i (dmem_wdata_o),
  .dmem_we_i    (dmem_we_o),
  .dmem_re_i    (dmem_re_o),
  .stall_i      (stall)
);

`default_nettype wire

// File: rtl/riscv_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_top (
  input  logic                  clk,
  input  logic                  rst_i,
  output riscv_pipe_pkg::word_t imem_addr_o,
  input  riscv_pipe_pkg::word_t imem_data_i,
  output riscv_pipe_pkg::word_t dmem_addr_o,
  output riscv_pipe_pkg::word_t dmem_wdata_o,
  output logic                  dmem_we_o,
  output logic                  dmem_re_o,
  input  riscv_pipe_pkg::word_t dmem_rdata_i
);

  import riscv_pipe_pkg::*;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  wb_t     wb;
  logic    stall;

  fetch_stage u_fetch_stage (
    .clk         (clk),
    .rst_i       (rst_i),
    .stall_i     (stall),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .if_id_o     (if_id)
  );

  decode_stage u_decode_stage (
    .clk     (clk),
    .rst_i   (rst_i),
    .if_id_i (if_id),
    .wb_i    (wb),
    .stall_o (stall),
    .id_ex_o (id_ex)
  );

  execute_stage u_execute_stage (
    .clk      (clk),
    .rst_i    (rst_i),
    .id_ex_i  (id_ex),
    .wb_i     (wb),
    .ex_mem_o (ex_mem)
  );

  mem_wb_stage u_mem_wb_stage (
    .clk          (clk),
    .rst_i        (rst_i),
    .ex_mem_i     (ex_mem),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_re_o    (dmem_re_o),
    .dmem_rdata_i (dmem_rdata_i),
    .wb_o         (wb)
  );

endmodule

`default_nettype wire

// File: rtl/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
  input  logic                    clk,
  input  logic                    rst_i,
  input  riscv_pipe_pkg::ex_mem_t ex_mem_i,
  output riscv_pipe_pkg::word_t   dmem_addr_o,
  output riscv_pipe_pkg::word_t   dmem_wdata_o,
  output logic                    dmem_we_o,
  output logic                    dmem_re_o,
  input  riscv_pipe_pkg::word_t   dmem_rdata_i,
  output riscv_pipe_pkg::wb_t     wb_o
);

  import riscv_pipe_pkg::*;

  mem_wb_t mem_wb_q;

  // ==========================================================
  // memory stage
  // ==========================================================

  // data port straight from the execute-memory register
  assign dmem_addr_o  = ex_mem_i.result;
  assign dmem_wdata_o = ex_mem_i.store_data;
  assign dmem_we_o    = ex_mem_i.mem_write;
  assign dmem_re_o    = ex_mem_i.mem_read;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mem_wb_q <= '0;
    end else begin
      mem_wb_q.rd        <= ex_mem_i.rd;
      mem_wb_q.result    <= ex_mem_i.result;
      mem_wb_q.reg_write <= ex_mem_i.reg_write;
      mem_wb_q.mem_read  <= ex_mem_i.mem_read;
    end
  end

  // ==========================================================
  // writeback
  // ==========================================================

  // read data arrives one cycle after the address
  assign wb_o.we   = mem_wb_q.reg_write;
  assign wb_o.rd   = mem_wb_q.rd;
  assign wb_o.data = mem_wb_q.mem_read ? dmem_rdata_i : mem_wb_q.result;

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                    clk,
  input  logic                    rst_i,
  input  riscv_pipe_pkg::id_ex_t  id_ex_i,
  input  riscv_pipe_pkg::wb_t     wb_i,
  output riscv_pipe_pkg::ex_mem_t ex_mem_o
);

  import riscv_pipe_pkg::*;

  word_t   op1;
  word_t   rs2_val;
  word_t   op2;
  word_t   alu_result;
  ex_mem_t ex_mem_d;
  ex_mem_t ex_mem_q;

  // ==========================================================
  // forwarding
  // ==========================================================

  // the memory stage has priority and a load there is covered by the stall
  function automatic word_t fwd(input reg_addr_t rs, input word_t dec_val,
                                input ex_mem_t mem, input wb_t wb);
    if (mem.reg_write && !mem.mem_read && mem.rd != '0 && mem.rd == rs) begin
      return mem.result;
    end
    if (wb.we && wb.rd != '0 && wb.rd == rs) begin
      return wb.data;
    end
    return dec_val;
  endfunction

  assign op1     = fwd(id_ex_i.rs1, id_ex_i.rdata1, ex_mem_q, wb_i);
  assign rs2_val = fwd(id_ex_i.rs2, id_ex_i.rdata2, ex_mem_q, wb_i);
  assign op2     = id_ex_i.alu_src ? id_ex_i.imm : rs2_val;

  // ==========================================================
  // alu
  // ==========================================================

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:  alu_result = op1 + op2;
      ALU_SUB:  alu_result = op1 - op2;
      ALU_AND:  alu_result = op1 & op2;
      ALU_OR:   alu_result = op1 | op2;
      ALU_XOR:  alu_result = op1 ^ op2;
      ALU_SLL:  alu_result = op1 << op2[4:0];
      ALU_SRL:  alu_result = op1 >> op2[4:0];
      ALU_SRA:  alu_result = $signed(op1) >>> op2[4:0];
      ALU_SLT:  alu_result = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_result = {31'b0, op1 < op2};
      default:  alu_result = op1 + op2;
    endcase
  end

  // lui bypasses the alu, loads and stores use the add path
  always_comb begin
    ex_mem_d.rd         = id_ex_i.rd;
    ex_mem_d.result     = id_ex_i.lui_sel ? id_ex_i.imm : alu_result;
    ex_mem_d.store_data = rs2_val;
    ex_mem_d.reg_write  = id_ex_i.reg_write;
    ex_mem_d.mem_read   = id_ex_i.mem_read;
    ex_mem_d.mem_write  = id_ex_i.mem_write;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_mem_q <= '0;
    end else begin
      ex_mem_q <= ex_mem_d;
    end
  end

  assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_pipe_consts.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    rst_i,
  input  riscv_pipe_pkg::if_id_t  if_id_i,
  input  riscv_pipe_pkg::wb_t     wb_i,
  output logic                    stall_o,
  output riscv_pipe_pkg::id_ex_t  id_ex_o
);

  import riscv_pipe_pkg::*;

  word_t       instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        funct7_b5;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  reg_addr_t   rd;
  word_t       rdata1;
  word_t       rdata2;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        load_use;
  id_ex_t      id_ex_d;
  id_ex_t      id_ex_q;

  // ==========================================================
  // instruction fields
  // ==========================================================

  assign instr     = if_id_i.instr;
  assign opcode    = instr[6:0];
  assign rd        = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign funct7_b5 = instr[30];

  reg_file u_reg_file (
    .clk      (clk),
    .rst_i    (rst_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wb_i     (wb_i)
  );

  // funct7 bit 5 only selects sub for register ops, sra for both
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ==========================================================
  // control decode and immediates
  // ==========================================================

  always_comb begin
    id_ex_d        = '0;
    id_ex_d.rs1    = rs1;
    id_ex_d.rs2    = rs2;
    id_ex_d.rd     = rd;
    id_ex_d.rdata1 = rdata1;
    id_ex_d.rdata2 = rdata2;
    id_ex_d.alu_op = ALU_ADD;
    uses_rs1       = 1'b0;
    uses_rs2       = 1'b0;
    case (opcode)
      `RP_OPC_OP: begin
        id_ex_d.alu_op    = alu_decode(funct3, funct7_b5, 1'b1);
        id_ex_d.reg_write = 1'b1;
        uses_rs1          = 1'b1;
        uses_rs2          = 1'b1;
      end
      `RP_OPC_OPIMM: begin
        id_ex_d.alu_op    = alu_decode(funct3, funct7_b5, 1'b0);
        id_ex_d.imm       = {{20{instr[31]}}, instr[31:20]};
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.reg_write = 1'b1;
        uses_rs1          = 1'b1;
      end
      `RP_OPC_LUI: begin
        id_ex_d.imm       = {instr[31:12], 12'b0};
        id_ex_d.lui_sel   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      `RP_OPC_LOAD: begin
        id_ex_d.imm       = {{20{instr[31]}}, instr[31:20]};
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.mem_read  = 1'b1;
        uses_rs1          = 1'b1;
      end
      `RP_OPC_STORE: begin
        id_ex_d.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        id_ex_d.alu_src   = 1'b1;
        id_ex_d.mem_write = 1'b1;
        uses_rs1          = 1'b1;
        uses_rs2          = 1'b1;
      end
      // anything else retires as a nop
      default: ;
    endcase
  end

  // load in execute feeding the instruction in decode
  assign load_use = id_ex_q.mem_read && (id_ex_q.rd != '0) &&
                    ((uses_rs1 && rs1 == id_ex_q.rd) || (uses_rs2 && rs2 == id_ex_q.rd));

  assign stall_o = load_use;

  // a stall sends a bubble and keeps the instruction in decode
  always_ff @(posedge clk) begin
    if (rst_i || load_use) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                      clk,
  input  logic                      rst_i,
  input  riscv_pipe_pkg::reg_addr_t raddr1_i,
  input  riscv_pipe_pkg::reg_addr_t raddr2_i,
  output riscv_pipe_pkg::word_t     rdata1_o,
  output riscv_pipe_pkg::word_t     rdata2_o,
  input  riscv_pipe_pkg::wb_t       wb_i
);

  import riscv_pipe_pkg::*;

  // x0 has no storage
  word_t regs_q [1:31];

  // write-through so decode sees the value retiring this cycle
  function automatic word_t read_port(input reg_addr_t addr, input wb_t wb,
                                      input word_t stored);
    if (addr == '0) begin
      return '0;
    end
    if (wb.we && wb.rd == addr) begin
      return wb.data;
    end
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.we && wb_i.rd != '0) begin
      regs_q[wb_i.rd] <= wb_i.data;
    end
  end

  assign rdata1_o = read_port(raddr1_i, wb_i, (raddr1_i == '0) ? '0 : regs_q[raddr1_i]);
  assign rdata2_o = read_port(raddr2_i, wb_i, (raddr2_i == '0) ? '0 : regs_q[raddr2_i]);

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_pipe_consts.svh"

module fetch_stage (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    stall_i,
  output riscv_pipe_pkg::word_t   imem_addr_o,
  input  riscv_pipe_pkg::word_t   imem_data_i,
  output riscv_pipe_pkg::if_id_t  if_id_o
);

  import riscv_pipe_pkg::*;

  word_t  pc_q;
  word_t  pc_plus4;
  if_id_t if_id_q;

  assign pc_plus4    = pc_q + `RP_PC_STEP;
  assign imem_addr_o = pc_q;

  // pc holds while decode waits on a load
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= `RP_RESET_PC;
    end else if (!stall_i) begin
      pc_q <= pc_plus4;
    end
  end

  // instruction memory answers in the same cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      if_id_q.pc    <= `RP_RESET_PC;
      if_id_q.instr <= `RP_NOP_INSTR;
    end else if (!stall_i) begin
      if_id_q.pc    <= pc_q;
      if_id_q.instr <= imem_data_i;
    end
  end

  assign if_id_o = if_id_q;

endmodule

`default_nettype wire

// File: rtl/riscv_pipe_pkg.sv
`default_nettype none

`include "riscv_pipe_consts.svh"

package riscv_pipe_pkg;

  // ==========================================================
  // basic vectors
  // ==========================================================

  typedef logic [`RP_XLEN-1:0] word_t;
  typedef logic [`RP_REG_AW-1:0] reg_addr_t;

  // alu operations that also serve as the control word down the pipe
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // ==========================================================
  // stage registers
  // ==========================================================

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rdata1;
    word_t     rdata2;
    word_t     imm;
    alu_op_e   alu_op;
    logic      alu_src;
    logic      lui_sel;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
  } id_ex_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     result;
    word_t     store_data;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
  } ex_mem_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     result;
    logic      reg_write;
    logic      mem_read;
  } mem_wb_t;

  // writeback bus to the register file and the forwarding logic
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

`default_nettype wire

// File: include/riscv_pipe_consts.svh
`ifndef RISCV_PIPE_CONSTS_SVH
`define RISCV_PIPE_CONSTS_SVH

// datapath and register index widths
`define RP_XLEN 32
`define RP_REG_AW 5

// program counter
`define RP_RESET_PC 32'h00000000
`define RP_PC_STEP 32'd4

// addi x0, x0, 0
`define RP_NOP_INSTR 32'h00000013

// major opcodes of the supported subset
`define RP_OPC_OP 7'b0110011
`define RP_OPC_OPIMM 7'b0010011
`define RP_OPC_LUI 7'b0110111
`define RP_OPC_LOAD 7'b0000011
`define RP_OPC_STORE 7'b0100011

`endif
